// ==== build.f ====
source/apb_sub_pkg.sv
source/ahb_to_apb_bridge.sv
source/alut_regs.sv
source/mac_ctrl_regs.sv
source/apb_subsystem.sv
source/switch_ctrl_top.sv
tests/switch_ctrl_assertions.sv
tests/tb_switch_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_switch_ctrl \
   -f build.f -o sim_switch_ctrl
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

sim_out=$(./obj_dir/sim_switch_ctrl)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1

// ==== source/ahb_to_apb_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module ahb_to_apb_bridge
   import apb_sub_pkg::*;
(
   // AHB-lite slave side
   input  logic                  hclk,
   input  logic                  rst_n,
   input  logic                  hsel,
   input  logic [31:0]           haddr,
   input  logic [1:0]            htrans,
   input  logic                  hwrite,
   input  logic [31:0]           hwdata,
   input  logic                  hready_in,
   output logic [31:0]           hrdata,
   output logic                  hready,
   output logic [1:0]            hresp,
   // APB master side
   output apb_req_t              apb_req,
   output logic [num_slaves-1:0] psel,
   input  apb_rsp_t              slave_rsp [num_slaves]
);

   typedef enum logic [2:0] {
      st_idle,
      st_setup,
      st_access,
      st_error1,
      st_error2
   } state_t;

   state_t                  state;
   state_t                  state_nxt;
   logic                    accept;
   logic [num_slaves-1:0]   dec_sel;
   logic [num_slaves-1:0]   sel_q;
   logic [31:0]             addr_q;
   logic                    write_q;
   logic [31:0]             wdata_q;
   logic [31:0]             hrdata_q;
   apb_rsp_t                sel_rsp;

   // ----------------------------------------------------------
   // Address phase
   // ----------------------------------------------------------
   // NONSEQ or SEQ, only while this slave is ready
   assign accept = hsel && htrans[1] && hready_in && hready;

   // Slave decode on the upper address half
   always_comb begin
      dec_sel = '0;
      case (haddr[31:16])
         alut_base: dec_sel[0] = 1'b1;
         mac0_base: dec_sel[1] = 1'b1;
         mac1_base: dec_sel[2] = 1'b1;
         mac2_base: dec_sel[3] = 1'b1;
         mac3_base: dec_sel[4] = 1'b1;
         default:   dec_sel = '0;
      endcase
   end

   // ----------------------------------------------------------
   // Transfer FSM
   // ----------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         // A new transfer may start in the last error cycle too
         st_idle, st_error2: begin
            if (accept) begin
               state_nxt = (|dec_sel) ? st_setup : st_error1;
            end else begin
               state_nxt = st_idle;
            end
         end
         st_setup:  state_nxt = st_access;
         // Held here while the slave stretches the access
         st_access: begin
            if (sel_rsp.pready) begin
               state_nxt = st_idle;
            end
         end
         st_error1: state_nxt = st_error2;
         default:   state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge hclk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= st_idle;
         sel_q   <= '0;
         write_q <= 1'b0;
      end else begin
         state <= state_nxt;
         if (accept) begin
            sel_q   <= dec_sel;
            write_q <= hwrite;
         end
      end
   end

   // Address and data payload
   always_ff @(posedge hclk) begin
      if (accept) begin
         addr_q <= haddr;
      end
      // Write data arrives in the AHB data phase
      if (state == st_setup) begin
         wdata_q <= hwdata;
      end
      if (state == st_access && sel_rsp.pready) begin
         hrdata_q <= sel_rsp.prdata;
      end
   end

   // Response of the selected slave
   always_comb begin
      sel_rsp = '0;
      for (int i = 0; i < num_slaves; i++) begin
         if (sel_q[i]) begin
            sel_rsp = slave_rsp[i];
         end
      end
   end

   // ----------------------------------------------------------
   // Outputs
   // ----------------------------------------------------------
   assign psel            = (state == st_setup || state == st_access) ? sel_q : '0;
   assign apb_req.paddr   = addr_q;
   assign apb_req.pwrite  = write_q;
   assign apb_req.penable = (state == st_access);
   // hwdata directly in setup, held copy afterwards
   assign apb_req.pwdata  = (state == st_setup) ? hwdata : wdata_q;

   assign hready = (state == st_idle) || (state == st_error2);
   assign hresp  = (state == st_error1 || state == st_error2) ? hresp_error : hresp_okay;
   assign hrdata = hrdata_q;

endmodule

`default_nettype wire

// ==== source/alut_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module alut_regs
   import apb_sub_pkg::*;
(
   input  logic     hclk,
   input  logic     rst_n,
   input  logic     psel,
   input  apb_req_t apb_req,
   output apb_rsp_t apb_rsp
);

   logic                             apb_wr;
   logic [6:0]                       offset;
   logic [31:0]                      mac_lo_q;
   logic [15:0]                      mac_hi_q;
   logic [port_w-1:0]                port_q;
   logic [47:0]                      staged_mac;
   // Table storage
   logic [alut_entries-1:0]          valid_q;
   logic [47:0]                      addr_tab [alut_entries];
   logic [port_w-1:0]                port_tab [alut_entries];
   // Search and learn
   logic                             match_found;
   logic [$clog2(alut_entries)-1:0]  match_idx;
   logic                             free_found;
   logic [$clog2(alut_entries)-1:0]  free_idx;
   logic                             learn_go;
   logic                             lookup_go;
   logic                             tab_we;
   logic [$clog2(alut_entries)-1:0]  tab_idx;
   // Lookup state
   logic                             busy_q;
   logic                             hit_q;
   logic                             full_q;
   logic [port_w-1:0]                res_port_q;
   logic [$clog2(alut_entries)-1:0]  scan_idx;
   logic [31:0]                      rdata;

   // Zero wait states, write in the access cycle
   assign apb_wr     = psel && apb_req.penable && apb_req.pwrite;
   assign offset     = apb_req.paddr[6:0];
   assign staged_mac = {mac_hi_q, mac_lo_q};

   // ----------------------------------------------------------
   // Staging registers
   // ----------------------------------------------------------
   always_ff @(posedge hclk or negedge rst_n) begin
      if (!rst_n) begin
         mac_lo_q <= '0;
         mac_hi_q <= '0;
         port_q   <= '0;
      end else if (apb_wr) begin
         if (offset == alut_mac_lo) mac_lo_q <= apb_req.pwdata;
         if (offset == alut_mac_hi) mac_hi_q <= apb_req.pwdata[15:0];
         if (offset == alut_port)   port_q   <= apb_req.pwdata[port_w-1:0];
      end
   end

   assign learn_go  = apb_wr && offset == alut_cmd && apb_req.pwdata[1:0] == cmd_learn;
   assign lookup_go = apb_wr && offset == alut_cmd && apb_req.pwdata[1:0] == cmd_lookup;

   // Matching entry, and lowest free entry
   always_comb begin
      match_found = 1'b0;
      match_idx   = '0;
      free_found  = 1'b0;
      free_idx    = '0;
      for (int i = alut_entries - 1; i >= 0; i--) begin
         if (valid_q[i] && addr_tab[i] == staged_mac) begin
            match_found = 1'b1;
            match_idx   = i[$clog2(alut_entries)-1:0];
         end
         if (!valid_q[i]) begin
            free_found = 1'b1;
            free_idx   = i[$clog2(alut_entries)-1:0];
         end
      end
   end

   // Update wins over a fresh fill
   assign tab_we  = learn_go && (match_found || free_found);
   assign tab_idx = match_found ? match_idx : free_idx;

   always_ff @(posedge hclk) begin
      if (tab_we) begin
         addr_tab[tab_idx] <= staged_mac;
         port_tab[tab_idx] <= port_q;
      end
   end

   // ----------------------------------------------------------
   // Valid bits, full flag, lookup scan
   // ----------------------------------------------------------
   always_ff @(posedge hclk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q    <= '0;
         full_q     <= 1'b0;
         busy_q     <= 1'b0;
         hit_q      <= 1'b0;
         res_port_q <= '0;
         scan_idx   <= '0;
      end else begin
         if (tab_we) begin
            valid_q[tab_idx] <= 1'b1;
         end else if (learn_go) begin
            full_q <= 1'b1;   // sticky until reset
         end
         if (lookup_go) begin
            busy_q   <= 1'b1;
            hit_q    <= 1'b0;
            scan_idx <= '0;
         end else if (busy_q) begin
            // One entry per cycle
            if (valid_q[scan_idx] && addr_tab[scan_idx] == staged_mac) begin
               hit_q      <= 1'b1;
               res_port_q <= port_tab[scan_idx];
               busy_q     <= 1'b0;
            end else if (int'(scan_idx) == alut_entries - 1) begin
               busy_q <= 1'b0;
            end else begin
               scan_idx <= scan_idx + 1'b1;
            end
         end
      end
   end

   // Read mux
   always_comb begin
      case (offset)
         alut_mac_lo: rdata = mac_lo_q;
         alut_mac_hi: rdata = {16'h0, mac_hi_q};
         alut_port:   rdata = {{(32-port_w){1'b0}}, port_q};
         alut_status: rdata = {{(29-port_w){1'b0}}, full_q, res_port_q, hit_q, busy_q};
         default:     rdata = '0;
      endcase
   end

   assign apb_rsp.prdata = rdata;
   assign apb_rsp.pready = 1'b1;

endmodule

`default_nettype wire

// ==== source/apb_sub_pkg.sv ====
`default_nettype none

package apb_sub_pkg;

   // ----------------------------------------------------------
   // Address map, upper half of each slave base address
   // ----------------------------------------------------------
   localparam logic [15:0] alut_base = 16'h00A0;
   localparam logic [15:0] mac0_base = 16'h00A1;
   localparam logic [15:0] mac1_base = 16'h00A2;
   localparam logic [15:0] mac2_base = 16'h00A3;
   localparam logic [15:0] mac3_base = 16'h00A4;
   localparam int num_slaves = 5;

   // ALUT register offsets
   localparam logic [6:0] alut_mac_lo = 7'h00;
   localparam logic [6:0] alut_mac_hi = 7'h04;
   localparam logic [6:0] alut_port   = 7'h08;
   localparam logic [6:0] alut_cmd    = 7'h0C;
   localparam logic [6:0] alut_status = 7'h10;

   // ALUT table and commands
   localparam int alut_entries = 8;
   localparam int port_w = 2;
   localparam logic [1:0] cmd_learn  = 2'd1;
   localparam logic [1:0] cmd_lookup = 2'd2;

   // MAC register offsets
   localparam logic [3:0] mac_ctrl      = 4'h0;
   localparam logic [3:0] mac_max_frame = 4'h4;
   localparam logic [3:0] mac_id        = 4'h8;
   localparam logic [3:0] mac_scratch   = 4'hC;
   localparam int max_frame_w = 14;

   // ----------------------------------------------------------
   // APB request, common to all slaves
   // ----------------------------------------------------------
   typedef struct packed {
      logic [31:0] paddr;
      logic        pwrite;
      logic        penable;
      logic [31:0] pwdata;
   } apb_req_t;

   // Per-slave response
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
   } apb_rsp_t;

   // AHB response codes
   localparam logic [1:0] hresp_okay  = 2'b00;
   localparam logic [1:0] hresp_error = 2'b01;

endpackage

`default_nettype wire

// ==== source/apb_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_subsystem
   import apb_sub_pkg::*;
(
   // AHB-lite
   input  logic        hclk,
   input  logic        rst_n,
   input  logic        hsel,
   input  logic [31:0] haddr,
   input  logic [1:0]  htrans,
   input  logic        hwrite,
   input  logic [31:0] hwdata,
   input  logic        hready_in,
   output logic [31:0] hrdata,
   output logic        hready,
   output logic [1:0]  hresp,
   // MAC APB ports
   output apb_req_t    apb_req,
   output logic [3:0]  mac_psel,
   input  apb_rsp_t    mac_rsp [4]
);

   logic [num_slaves-1:0] psel;
   apb_rsp_t              slave_rsp [num_slaves];

   // Slave 0 is the ALUT, 1 to 4 the MACs
   assign mac_psel     = psel[4:1];
   assign slave_rsp[1] = mac_rsp[0];
   assign slave_rsp[2] = mac_rsp[1];
   assign slave_rsp[3] = mac_rsp[2];
   assign slave_rsp[4] = mac_rsp[3];

   ahb_to_apb_bridge u_ahb_to_apb_bridge (
      .hclk      (hclk),
      .rst_n     (rst_n),
      .hsel      (hsel),
      .haddr     (haddr),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hwdata    (hwdata),
      .hready_in (hready_in),
      .hrdata    (hrdata),
      .hready    (hready),
      .hresp     (hresp),
      .apb_req   (apb_req),
      .psel      (psel),
      .slave_rsp (slave_rsp)
   );

   alut_regs u_alut_regs (
      .hclk    (hclk),
      .rst_n   (rst_n),
      .psel    (psel[0]),
      .apb_req (apb_req),
      .apb_rsp (slave_rsp[0])
   );

endmodule

`default_nettype wire

// ==== source/mac_ctrl_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module mac_ctrl_regs
   import apb_sub_pkg::*;
#(
   parameter int mac_index = 0
) (
   input  logic     hclk,
   input  logic     rst_n,
   input  logic     psel,
   input  apb_req_t apb_req,
   output apb_rsp_t apb_rsp
);

   logic                   wait_q;
   logic                   access;
   logic                   apb_wr;
   logic [3:0]             offset;
   logic [31:0]            ctrl_q;
   logic [max_frame_w-1:0] max_frame_q;
   logic [31:0]            scratch_q;
   logic [31:0]            rdata;

   assign access = psel && apb_req.penable;
   assign offset = apb_req.paddr[3:0];

   // First access cycle stalls, second completes
   always_ff @(posedge hclk or negedge rst_n) begin
      if (!rst_n) begin
         wait_q <= 1'b0;
      end else begin
         wait_q <= access && !wait_q;
      end
   end

   // Commit only in the completing cycle
   assign apb_wr = access && wait_q && apb_req.pwrite;

   always_ff @(posedge hclk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_q      <= '0;
         max_frame_q <= '0;
         scratch_q   <= '0;
      end else if (apb_wr) begin
         if (offset == mac_ctrl)      ctrl_q      <= apb_req.pwdata;
         if (offset == mac_max_frame) max_frame_q <= apb_req.pwdata[max_frame_w-1:0];
         if (offset == mac_scratch)   scratch_q   <= apb_req.pwdata;
      end
   end

   // Read mux, ID is fixed per port
   always_comb begin
      case (offset)
         mac_ctrl:      rdata = ctrl_q;
         mac_max_frame: rdata = {{(32-max_frame_w){1'b0}}, max_frame_q};
         mac_id:        rdata = 32'(mac_index);
         mac_scratch:   rdata = scratch_q;
         default:       rdata = '0;
      endcase
   end

   assign apb_rsp.prdata = rdata;
   assign apb_rsp.pready = wait_q;

endmodule

`default_nettype wire

// ==== source/switch_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module switch_ctrl_top
   import apb_sub_pkg::*;
(
   input  logic        hclk,
   input  logic        rst_n,
   input  logic        hsel,
   input  logic [31:0] haddr,
   input  logic [1:0]  htrans,
   input  logic        hwrite,
   input  logic [31:0] hwdata,
   input  logic        hready_in,
   output logic [31:0] hrdata,
   output logic        hready,
   output logic [1:0]  hresp
);

   apb_req_t   apb_req;
   logic [3:0] mac_psel;
   apb_rsp_t   mac_rsp [4];

   apb_subsystem u_apb_subsystem (
      .hclk      (hclk),
      .rst_n     (rst_n),
      .hsel      (hsel),
      .haddr     (haddr),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hwdata    (hwdata),
      .hready_in (hready_in),
      .hrdata    (hrdata),
      .hready    (hready),
      .hresp     (hresp),
      .apb_req   (apb_req),
      .mac_psel  (mac_psel),
      .mac_rsp   (mac_rsp)
   );

   // One register block per switch port
   for (genvar i = 0; i < 4; i++) begin : g_mac
      mac_ctrl_regs #(
         .mac_index (i)
      ) u_mac_ctrl_regs (
         .hclk    (hclk),
         .rst_n   (rst_n),
         .psel    (mac_psel[i]),
         .apb_req (apb_req),
         .apb_rsp (mac_rsp[i])
      );
   end

endmodule

`default_nettype wire

// ==== tests/switch_ctrl_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module switch_ctrl_assertions
   import apb_sub_pkg::*;
(
   input logic                  hclk,
   input logic                  rst_n,
   input logic                  hready,
   input logic [1:0]            hresp,
   input logic [num_slaves-1:0] psel,
   input apb_req_t              apb_req,
   input logic                  pready
);

   // Count of failed checks below
   int fail_count = 0;

   // At most one APB slave selected
   a_psel_onehot: assert property (@(posedge hclk) disable iff (!rst_n)
      $onehot0(psel))
      else begin
         fail_count++;
         $error("psel has more than one bit set");
      end

   // Access phase only after a setup cycle with psel high
   a_penable_after_setup: assert property (@(posedge hclk) disable iff (!rst_n)
      $rose(apb_req.penable) |-> (|psel) && $past(|psel))
      else begin
         fail_count++;
         $error("penable rose without a setup cycle");
      end

   // Stretched access keeps the request steady
   a_req_stable: assert property (@(posedge hclk) disable iff (!rst_n)
      ((|psel) && apb_req.penable && !pready) |=>
         $stable(apb_req.paddr) && $stable(apb_req.pwrite) && $stable(apb_req.pwdata))
      else begin
         fail_count++;
         $error("APB request changed while the slave was waiting");
      end

   // Two-cycle ERROR, stalled first
   a_error_second: assert property (@(posedge hclk) disable iff (!rst_n)
      (hresp == hresp_error && !hready) |=> (hresp == hresp_error && hready))
      else begin
         fail_count++;
         $error("ERROR response missing its second cycle");
      end

   a_error_first: assert property (@(posedge hclk) disable iff (!rst_n)
      (hresp == hresp_error && hready) |-> $past(hresp == hresp_error && !hready))
      else begin
         fail_count++;
         $error("ERROR response without a stalled first cycle");
      end

endmodule

bind ahb_to_apb_bridge switch_ctrl_assertions u_switch_ctrl_assertions (
   .hclk    (hclk),
   .rst_n   (rst_n),
   .hready  (hready),
   .hresp   (hresp),
   .psel    (psel),
   .apb_req (apb_req),
   .pready  (sel_rsp.pready)
);

`default_nettype wire

// ==== tests/switch_ctrl_golden.txt ====
# op addr data resp: W write, R read with expected data, P poll ALUT status until not busy
# addr and data in hex, resp 0 OKAY or 1 ERROR
# MAC0 to MAC3: ctrl, max_frame masked to 14 bits, id, scratch
W 00a10000 c0de0001 0
W 00a10004 0000ffff 0
W 00a1000c 5a5a0000 0
R 00a10000 c0de0001 0
R 00a10004 00003fff 0
R 00a10008 00000000 0
R 00a1000c 5a5a0000 0
W 00a20000 c0de0002 0
W 00a20004 000105ee 0
W 00a2000c 5a5a1111 0
R 00a20000 c0de0002 0
R 00a20004 000005ee 0
R 00a20008 00000001 0
R 00a2000c 5a5a1111 0
W 00a30000 c0de0003 0
W 00a30004 12345678 0
W 00a3000c 5a5a2222 0
R 00a30000 c0de0003 0
R 00a30004 00001678 0
R 00a30008 00000002 0
R 00a3000c 5a5a2222 0
W 00a40000 c0de0004 0
W 00a40004 000025ee 0
W 00a4000c 5a5a3333 0
W 00a40008 ffffffff 0
R 00a40000 c0de0004 0
R 00a40004 000025ee 0
R 00a40008 00000003 0
R 00a4000c 5a5a3333 0
# ALUT learn two addresses, look both up, miss an unlearned one
W 00a00004 00001234 0
R 00a00004 00001234 0
W 00a00000 aaaa0001 0
W 00a00008 00000001 0
W 00a0000c 00000001 0
W 00a00000 aaaa0002 0
W 00a00008 00000002 0
W 00a0000c 00000001 0
W 00a00000 aaaa0001 0
W 00a0000c 00000002 0
P 00a00010 00000006 0
W 00a00000 aaaa0002 0
W 00a0000c 00000002 0
P 00a00010 0000000a 0
W 00a00000 aaaa0009 0
W 00a0000c 00000002 0
P 00a00010 00000008 0
R 00a00014 00000000 0
# ALUT relearn with a new port, then fill all eight entries
W 00a00000 aaaa0001 0
W 00a00008 00000003 0
W 00a0000c 00000001 0
W 00a0000c 00000002 0
P 00a00010 0000000e 0
W 00a00000 aaaa0003 0
W 00a0000c 00000001 0
W 00a00000 aaaa0004 0
W 00a0000c 00000001 0
W 00a00000 aaaa0005 0
W 00a0000c 00000001 0
W 00a00000 aaaa0006 0
W 00a0000c 00000001 0
W 00a00000 aaaa0007 0
W 00a0000c 00000001 0
W 00a00000 aaaa0008 0
W 00a0000c 00000001 0
# Ninth learn sets full and misses
W 00a00000 aaaa0009 0
W 00a0000c 00000001 0
W 00a00000 aaaa0008 0
W 00a0000c 00000002 0
P 00a00010 0000001e 0
W 00a00000 aaaa0009 0
W 00a0000c 00000002 0
P 00a00010 0000001c 0
# Unmapped address, MAC0 scratch unchanged
W 00b00000 deadbeef 1
R 00b00000 00000000 1
R 00a1000c 5a5a0000 0
R 00a20000 c0de0002 0
R 00a30004 00001678 0
R 00a40008 00000003 0

// ==== tests/tb_switch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_switch_ctrl
   import apb_sub_pkg::*;
();

   logic        hclk;
   logic        rst_n;
   logic        hsel;
   logic [31:0] haddr;
   logic [1:0]  htrans;
   logic        hwrite;
   logic [31:0] hwdata;
   logic        hready_in;
   logic [31:0] hrdata;
   logic        hready;
   logic [1:0]  hresp;

   // Transfer list from the golden file
   logic [7:0]  op_q   [$];
   logic [31:0] addr_q [$];
   logic [31:0] data_q [$];
   logic        resp_q [$];

   logic [31:0] lfsr;
   int          errors;
   int          tests_passed;
   int          tests_failed;
   int          cycles;
   int          cycle_limit;
   int          assert_fails;
   bit          loaded;

   switch_ctrl_top u_switch_ctrl_top (
      .hclk      (hclk),
      .rst_n     (rst_n),
      .hsel      (hsel),
      .haddr     (haddr),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hwdata    (hwdata),
      .hready_in (hready_in),
      .hrdata    (hrdata),
      .hready    (hready),
      .hresp     (hresp)
   );

   // 40 ns period
   always #20 hclk = ~hclk;

   // Watchdog on total cycles
   always @(posedge hclk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles, transfer list did not complete", cycles);
         $display("Finished with errors");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------
   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   // 0 to 7 idle cycles, one LFSR step per bit
   task automatic idle_gap();
      logic [2:0] gap;
      gap = '0;
      for (int b = 0; b < 3; b++) begin
         gap  = {gap[1:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      repeat (gap) @(posedge hclk);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("FAIL %s expected %08h actual %08h", name, expected, actual);
         errors++;
      end
   endtask

   // Single NONSEQ transfer, address phase held while hready low
   task automatic ahb_transfer(input logic wr, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic [1:0] resp);
      @(posedge hclk);
      hsel   <= 1'b1;
      htrans <= 2'b10;
      haddr  <= addr;
      hwrite <= wr;
      do begin
         @(negedge hclk);
      end while (!hready);
      // Accepting edge, data phase follows
      @(posedge hclk);
      hsel   <= 1'b0;
      htrans <= 2'b00;
      hwdata <= wdata;
      do begin
         @(negedge hclk);
      end while (!hready);
      rdata = hrdata;
      resp  = hresp;
   endtask

   // ------------------------------------------------------------
   // Golden file
   // ------------------------------------------------------------
   task automatic load_golden(output bit ok);
      int          fd;
      int          r;
      int          ch;
      int          resp_val;
      bit          done;
      bit          bad;
      logic [7:0]  op;
      logic [31:0] addr;
      logic [31:0] data;
      done = 1'b0;
      bad  = 1'b0;
      fd   = $fopen("tests/switch_ctrl_golden.txt", "r");
      if (fd == 0) begin
         bad = 1'b1;
      end else begin
         while (!done) begin
            r = $fscanf(fd, " %c", op);
            if (r != 1) begin
               done = 1'b1;
            end else if (op == "#") begin
               // Skip rest of comment line
               ch = $fgetc(fd);
               while (ch != 10 && ch != -1) begin
                  ch = $fgetc(fd);
               end
            end else begin
               r = $fscanf(fd, "%h %h %d", addr, data, resp_val);
               if (r == 3 && (op == "W" || op == "R" || op == "P")) begin
                  op_q.push_back(op);
                  addr_q.push_back(addr);
                  data_q.push_back(data);
                  resp_q.push_back(resp_val != 0);
               end else begin
                  $display("Golden file entry %0d is malformed", op_q.size() + 1);
                  bad  = 1'b1;
                  done = 1'b1;
               end
            end
         end
         $fclose(fd);
      end
      ok = !bad && op_q.size() > 0;
   endtask

   // One golden entry; P re-reads ALUT status while busy
   task automatic run_one(input int idx);
      string       name;
      logic [7:0]  op;
      logic [31:0] addr;
      logic [31:0] exp_data;
      logic [1:0]  exp_resp;
      logic [31:0] rdata;
      logic [1:0]  resp;
      int          errors_before;
      int          polls;
      op            = op_q[idx];
      addr          = addr_q[idx];
      exp_data      = data_q[idx];
      exp_resp      = resp_q[idx] ? hresp_error : hresp_okay;
      name          = $sformatf("#%0d %c %08h", idx + 1, op, addr);
      errors_before = errors;
      polls         = 0;
      case (op)
         "W": begin
            ahb_transfer(1'b1, addr, exp_data, rdata, resp);
         end
         "R": begin
            ahb_transfer(1'b0, addr, 32'h0, rdata, resp);
         end
         default: begin
            do begin
               ahb_transfer(1'b0, addr, 32'h0, rdata, resp);
               polls++;
            end while (rdata[0] && resp == hresp_okay && polls < 16);
            if (rdata[0] && resp == hresp_okay) begin
               $display("ALUT still busy after %0d status reads in %s", polls, name);
               errors++;
            end
         end
      endcase
      check_value({name, " resp"}, {30'h0, exp_resp}, {30'h0, resp});
      // Read data only means something on OKAY
      if (op != "W" && exp_resp == hresp_okay) begin
         check_value(name, exp_data, rdata);
      end
      if (errors == errors_before) begin
         $display("test %s ok", name);
         tests_passed++;
      end else begin
         $display("test %s failed", name);
         tests_failed++;
      end
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin
      hclk         = 1'b0;
      rst_n       <= 1'b0;
      hsel        <= 1'b0;
      haddr       <= '0;
      htrans      <= 2'b00;
      hwrite      <= 1'b0;
      hwdata      <= '0;
      hready_in   <= 1'b1;
      cycles      <= 0;
      lfsr         = 32'hd213acfd;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      cycle_limit  = 0;
      load_golden(loaded);
      // 20 cycles per entry on top of reset
      cycle_limit = op_q.size() * 20 + 16;
      repeat (16) @(posedge hclk);
      rst_n <= 1'b1;
      if (loaded) begin
         for (int i = 0; i < op_q.size(); i++) begin
            idle_gap();
            run_one(i);
         end
      end else begin
         $display("Golden file could not be read, no transfers were run");
         errors++;
      end
      // Protocol failures seen by the bound checker
      assert_fails =
         u_switch_ctrl_top.u_apb_subsystem.u_ahb_to_apb_bridge.u_switch_ctrl_assertions.fail_count;
      if (assert_fails != 0) begin
         $display("Bridge protocol assertions failed %0d times", assert_fails);
         errors += assert_fails;
      end
      $display("Tests %0d, passed %0d, failed %0d, errors %0d",
               tests_passed + tests_failed, tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire
